// ==== hw/noc_pkg.sv ====
// shared sizing constants and flit layouts for the router output port, used by scoped names
`default_nettype none

package noc_pkg;

  // port sizing
  localparam int unsigned N_INPUTS = 4;
  localparam int unsigned IDX_W = 2;
  localparam int unsigned FLIT_W = 32;

  // per-input buffer sizing
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned PTR_W = 2;
  localparam int unsigned CNT_W = 3;

  // header field widths
  localparam int unsigned SRC_W = 2;
  localparam int unsigned LEN_W = 4;
  localparam int unsigned TAG_W = FLIT_W - 2 - SRC_W - LEN_W;

  // body payload width, everything below the two framing bits
  localparam int unsigned DATA_W = FLIT_W - 2;

  // view of the first flit of a packet
  typedef struct packed {
    // set on the final flit, so a one-flit packet has both bits set
    logic             last;
    logic             head;
    // input link the packet came in on
    logic [SRC_W-1:0] src;
    // count of body flits that follow, informational only
    logic [LEN_W-1:0] len;
    logic [TAG_W-1:0] tag;
  } flit_hdr_t;

  // view of every later flit
  typedef struct packed {
    logic              last;
    logic              head;
    logic [DATA_W-1:0] data;
  } flit_body_t;

  // one flit word, read as header or body
  // last and head share the top two bits in both views
  typedef union packed {
    flit_hdr_t  hdr;
    flit_body_t body;
  } flit_t;

  // idle flit value, neither head nor last
  localparam flit_t FLIT_IDLE = '0;

  // typical packet bounds
  localparam int unsigned MAX_BODY = (1 << LEN_W) - 1;

endpackage

`default_nettype wire

// ==== hw/flit_fifo.sv ====
// per-input flit buffer, written by a valid strobe and popped by the output stage
`timescale 1ns/1ps
`default_nettype none

module flit_fifo (
  input  wire                 clk,
  input  wire                 rst_n,
  input  logic                wr_i,
  input  noc_pkg::flit_t      wr_flit_i,
  input  logic                pop_i,
  output logic                head_valid_o,
  output noc_pkg::flit_t      head_flit_o,
  output logic                full_o
);

  noc_pkg::flit_t mem [noc_pkg::FIFO_DEPTH];

  logic [noc_pkg::PTR_W-1:0] wr_ptr_q;
  logic [noc_pkg::PTR_W-1:0] rd_ptr_q;
  logic [noc_pkg::CNT_W-1:0] count_q;

  logic do_wr;
  logic do_pop;

  assign head_valid_o = (count_q != '0);
  assign full_o       = (count_q == noc_pkg::CNT_W'(noc_pkg::FIFO_DEPTH));
  assign head_flit_o  = mem[rd_ptr_q];

  // a write while full is dropped, a pop while empty is ignored
  assign do_wr  = wr_i && !full_o;
  assign do_pop = pop_i && head_valid_o;

  // storage, the head is readable right after the writing edge
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr_q] <= wr_flit_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // occupancy, a write and a pop together leave it unchanged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else begin
      case ({do_wr, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // the sender must watch full before strobing
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) !(wr_i && full_o)
  ) else $error("flit buffer written while full");

  // the output stage may only pop a buffer that shows a head flit
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n) !(pop_i && !head_valid_o)
  ) else $error("flit buffer popped while empty");

endmodule

`default_nettype wire

// ==== hw/rr_arbiter.sv ====
// round-robin arbiter over the head requests, pointer advances only on an update pulse
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  wire                               clk,
  input  wire                               rst_n,
  input  logic [noc_pkg::N_INPUTS-1:0]      req_i,
  input  logic                              update_i,
  output logic [noc_pkg::N_INPUTS-1:0]      grant_o,
  output logic [noc_pkg::IDX_W-1:0]         grant_idx_o
);

  // input that currently has first priority
  logic [noc_pkg::IDX_W-1:0] prio_q;

  logic [2*noc_pkg::N_INPUTS-1:0] req_dbl;
  logic [noc_pkg::N_INPUTS-1:0]   req_rot;
  logic [noc_pkg::N_INPUTS-1:0]   sel_rot;
  logic [2*noc_pkg::N_INPUTS-1:0] sel_dbl;

  // rotate right so the priority input lands on bit 0
  assign req_dbl = {req_i, req_i} >> prio_q;
  assign req_rot = req_dbl[noc_pkg::N_INPUTS-1:0];

  // keep only the lowest set bit
  assign sel_rot = req_rot & (~req_rot + 1'b1);

  // rotate back into input order
  assign sel_dbl = {sel_rot, sel_rot} << prio_q;
  assign grant_o = sel_dbl[2*noc_pkg::N_INPUTS-1:noc_pkg::N_INPUTS];

  // one-hot to index
  always_comb begin
    grant_idx_o = '0;
    for (int i = 0; i < noc_pkg::N_INPUTS; i++) begin
      if (grant_o[i]) begin
        grant_idx_o = noc_pkg::IDX_W'(i);
      end
    end
  end

  // the input after the winner gets first pick next time
  // index wraps by width since N_INPUTS is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_q <= '0;
    end else if (update_i) begin
      prio_q <= grant_idx_o + 1'b1;
    end
  end

  a_grant_onehot0: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(grant_o)
  ) else $error("arbiter grant is not one-hot");

  // no request may be left waiting without some grant
  a_grant_when_req: assert property (
    @(posedge clk) disable iff (!rst_n) (req_i != '0) |-> (grant_o != '0)
  ) else $error("arbiter has requests but no grant");

  // a pulse from the output stage must match a live grant
  a_update_with_grant: assert property (
    @(posedge clk) disable iff (!rst_n) update_i |-> ((grant_o & req_i) != '0)
  ) else $error("arbiter updated without a granted request");

endmodule

`default_nettype wire

// ==== hw/out_stage.sv ====
// output stage of the port: wormhole lock, flit select, output register and arbiter update
`timescale 1ns/1ps
`default_nettype none

module out_stage (
  input  wire                            clk,
  input  wire                            rst_n,
  input  logic [noc_pkg::N_INPUTS-1:0]   head_valid_i,
  input  noc_pkg::flit_t                 head_flit_i [noc_pkg::N_INPUTS],
  input  logic [noc_pkg::N_INPUTS-1:0]   grant_i,
  input  logic [noc_pkg::IDX_W-1:0]      grant_idx_i,
  output logic [noc_pkg::N_INPUTS-1:0]   req_o,
  output logic                           update_o,
  output logic [noc_pkg::N_INPUTS-1:0]   pop_o,
  input  logic                           out_ready_i,
  output logic                           out_valid_o,
  output noc_pkg::flit_t                 out_flit_o
);

  // wormhole lock state
  logic                        locked_q;
  logic [noc_pkg::IDX_W-1:0]   lock_idx_q;

  // output register
  logic                        out_valid_q;
  noc_pkg::flit_t              out_flit_q;

  logic                        advance;
  logic [noc_pkg::IDX_W-1:0]   sel_idx;
  logic                        sel_valid;
  noc_pkg::flit_t              sel_flit;
  logic                        pop_go;

  // only a buffer showing a packet start competes
  always_comb begin
    for (int k = 0; k < noc_pkg::N_INPUTS; k++) begin
      req_o[k] = head_valid_i[k] && head_flit_i[k].hdr.head;
    end
  end

  // register is free, or its flit leaves this cycle
  assign advance = !out_valid_q || out_ready_i;

  // locked input has the floor until its last flit, otherwise the arbiter decides
  assign sel_idx   = locked_q ? lock_idx_q : grant_idx_i;
  assign sel_valid = locked_q ? head_valid_i[lock_idx_q] : (|grant_i);
  assign sel_flit  = head_flit_i[sel_idx];

  assign pop_go = advance && sel_valid;

  always_comb begin
    pop_o    = '0;
    update_o = 1'b0;
    if (pop_go) begin
      pop_o[sel_idx] = 1'b1;
      // arbiter moves on once per packet, at its head flit
      update_o = !locked_q;
    end
  end

  // take the lock on a head flit, drop it on the last one
  // a single-flit packet never locks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked_q   <= 1'b0;
      lock_idx_q <= '0;
    end else if (pop_go) begin
      if (!locked_q) begin
        if (!sel_flit.hdr.last) begin
          locked_q   <= 1'b1;
          lock_idx_q <= sel_idx;
        end
      end else if (sel_flit.body.last) begin
        locked_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid_q <= 1'b0;
    end else if (pop_go) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // payload only moves with a pop, so it holds while downstream stalls
  always_ff @(posedge clk) begin
    if (pop_go) begin
      out_flit_q <= sel_flit;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_flit_o  = out_flit_q;

  a_one_pop: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(pop_o)
  ) else $error("more than one buffer popped in a cycle");

  // a new packet inside a locked one means two packets got interleaved
  a_no_head_while_locked: assert property (
    @(posedge clk) disable iff (!rst_n) (locked_q && pop_go) |-> !sel_flit.body.head
  ) else $error("head flit popped from a locked input");

endmodule

`default_nettype wire

// ==== hw/noc_out_port.sv ====
// top level of the router output port: four input buffers, the arbiter and the output stage
`timescale 1ns/1ps
`default_nettype none

module noc_out_port (
  input  wire                            clk,
  input  wire                            rst_n,
  input  logic [noc_pkg::N_INPUTS-1:0]   in_valid_i,
  input  noc_pkg::flit_t                 in_flit_i [noc_pkg::N_INPUTS],
  output logic [noc_pkg::N_INPUTS-1:0]   in_full_o,
  input  logic                           out_ready_i,
  output logic                           out_valid_o,
  output noc_pkg::flit_t                 out_flit_o
);

  // buffer heads toward arbiter and output stage
  logic [noc_pkg::N_INPUTS-1:0]   head_valid;
  noc_pkg::flit_t                 head_flit [noc_pkg::N_INPUTS];
  logic [noc_pkg::N_INPUTS-1:0]   pop;

  // arbitration
  logic [noc_pkg::N_INPUTS-1:0]   req;
  logic [noc_pkg::N_INPUTS-1:0]   grant;
  logic [noc_pkg::IDX_W-1:0]      grant_idx;
  logic                           update;

  for (genvar k = 0; k < noc_pkg::N_INPUTS; k++) begin : g_in
    flit_fifo u_fifo (
      .clk          (clk),
      .rst_n        (rst_n),
      .wr_i         (in_valid_i[k]),
      .wr_flit_i    (in_flit_i[k]),
      .pop_i        (pop[k]),
      .head_valid_o (head_valid[k]),
      .head_flit_o  (head_flit[k]),
      .full_o       (in_full_o[k])
    );
  end

  rr_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req),
    .update_i    (update),
    .grant_o     (grant),
    .grant_idx_o (grant_idx)
  );

  out_stage u_out (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_valid_i (head_valid),
    .head_flit_i  (head_flit),
    .grant_i      (grant),
    .grant_idx_i  (grant_idx),
    .req_o        (req),
    .update_o     (update),
    .pop_o        (pop),
    .out_ready_i  (out_ready_i),
    .out_valid_o  (out_valid_o),
    .out_flit_o   (out_flit_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_noc_out_port.sv ====
// directed testbench for the router output port, built from sources.f with tb_noc_out_port on top
`timescale 1ns/1ps
`default_nettype none

module tb_noc_out_port;

  localparam int TIMEOUT = 2000;

  logic                          clk;
  logic                          rst_n;
  logic [noc_pkg::N_INPUTS-1:0]  in_valid;
  noc_pkg::flit_t                in_flit [noc_pkg::N_INPUTS];
  logic [noc_pkg::N_INPUTS-1:0]  in_full;
  logic                          out_ready;
  logic                          out_valid;
  noc_pkg::flit_t                out_flit;

  integer seed = 32'h15472f4e;
  int     errors = 0;
  int     checks = 0;

  // flits still owed per input, and the source of each packet head in arrival order
  logic [noc_pkg::FLIT_W-1:0] exp_q [noc_pkg::N_INPUTS][$];
  int                         order_q [$];

  // packet being collected
  logic           in_pkt = 1'b0;
  int             cur_src = 0;
  // input expected to have first pick, advanced by the round-robin rule
  int             next_prio = 0;
  logic           hold_pending = 1'b0;
  noc_pkg::flit_t held_flit;

  noc_out_port dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .in_full_o   (in_full),
    .out_ready_i (out_ready),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0d ns: %s", $time, msg);
  endtask

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int k = 0; k < noc_pkg::N_INPUTS; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  // match one taken flit against the packet it belongs to
  task automatic take_flit(input noc_pkg::flit_t f);
    if (f.hdr.head) begin
      if (in_pkt) begin
        report_error("a new packet started before the previous one ended");
      end
      cur_src = int'(f.hdr.src);
      in_pkt  = 1'b1;
      order_q.push_back(cur_src);
    end else if (!in_pkt) begin
      report_error("a body flit left the port outside any packet");
      return;
    end
    if (exp_q[cur_src].size() == 0) begin
      report_error($sformatf("input %0d sent a flit that was never written", cur_src));
    end else begin
      check_value("out_flit_o", f, exp_q[cur_src].pop_front());
    end
    if (f.body.last) begin
      in_pkt = 1'b0;
    end
  endtask

  // output monitor samples the values that the DUT saw at this edge
  always @(posedge clk) begin
    if (!rst_n) begin
      hold_pending = 1'b0;
      in_pkt       = 1'b0;
      next_prio    = 0;
    end else begin
      if (hold_pending) begin
        check_value("out_flit_o while held", out_flit, held_flit);
        check_value("out_valid_o while held", out_valid, 1'b1);
      end
      hold_pending = out_valid && !out_ready;
      held_flit    = out_flit;
      if (out_valid && out_ready) begin
        take_flit(out_flit);
      end
    end
  end

  task automatic apply_reset();
    rst_n     <= 1'b0;
    in_valid  <= '0;
    out_ready <= 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int k = 0; k < noc_pkg::N_INPUTS; k++) begin
      exp_q[k].delete();
    end
    order_q.delete();
    @(posedge clk);
  endtask

  // one flit every two cycles, so full is always seen after the previous write
  task automatic send_packet(input int k, input int nbody);
    noc_pkg::flit_t f;
    int             waited;
    for (int i = 0; i <= nbody; i++) begin
      if (i == 0) begin
        f.hdr.last = (nbody == 0);
        f.hdr.head = 1'b1;
        f.hdr.src  = noc_pkg::SRC_W'(k);
        f.hdr.len  = noc_pkg::LEN_W'(nbody);
        f.hdr.tag  = noc_pkg::TAG_W'($random(seed));
      end else begin
        f.body.last = (i == nbody);
        f.body.head = 1'b0;
        f.body.data = noc_pkg::DATA_W'($random(seed));
      end
      waited = 0;
      @(posedge clk);
      while (in_full[k] && waited < TIMEOUT) begin
        @(posedge clk);
        waited++;
      end
      if (in_full[k]) begin
        report_error($sformatf("input %0d stayed full, packet not sent", k));
        return;
      end
      exp_q[k].push_back(f);
      in_flit[k]  <= f;
      in_valid[k] <= 1'b1;
      @(posedge clk);
      in_valid[k] <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((pending_flits() != 0 || out_valid) && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (pending_flits() != 0 || out_valid) begin
      report_error("timed out waiting for the port to drain");
    end
  endtask

  // packets whose heads arrived together leave in rotation from the priority input
  // the last expected winner hands first pick to the input after it
  task automatic check_order(input logic [noc_pkg::N_INPUTS-1:0] mask, input int start);
    int k;
    int pos;
    pos = 0;
    for (int i = 0; i < noc_pkg::N_INPUTS; i++) begin
      k = (start + i) % noc_pkg::N_INPUTS;
      if (mask[k]) begin
        if (pos < order_q.size()) begin
          check_value("packet source order", order_q[pos], k);
        end else begin
          report_error("a packet never left the port");
        end
        pos++;
        next_prio = (k + 1) % noc_pkg::N_INPUTS;
      end
    end
    if (order_q.size() > pos) begin
      report_error("more packets left the port than were sent");
    end
    order_q.delete();
  endtask

  task automatic reset_and_single_packet();
    int start;
    apply_reset();
    check_value("out_valid_o", out_valid, 1'b0);
    check_value("in_full_o", in_full, '0);
    start = next_prio;
    send_packet(2, 2);
    wait_drain();
    check_order(4'b0100, start);
  endtask

  task automatic round_robin_order();
    int start;
    apply_reset();
    repeat (2) begin
      start = next_prio;
      out_ready <= 1'b0;
      fork
        send_packet(0, 0);
        send_packet(1, 0);
        send_packet(2, 0);
        send_packet(3, 0);
      join
      out_ready <= 1'b1;
      wait_drain();
      check_order(4'b1111, start);
    end
  endtask

  task automatic wormhole_lock();
    int start;
    apply_reset();
    start = next_prio;
    fork
      send_packet(0, 3);
      send_packet(1, 1);
      send_packet(2, 5);
      send_packet(3, 2);
    join
    wait_drain();
    check_order(4'b1111, start);
    start = next_prio;
    fork
      send_packet(1, 4);
      send_packet(3, 2);
    join
    wait_drain();
    check_order(4'b1010, start);
  endtask

  task automatic backpressure_stream();
    logic senders_done;
    int   stretch;
    int   guard;
    apply_reset();
    senders_done = 1'b0;
    guard = 0;
    fork
      begin
        fork
          begin
            send_packet(0, 2);
            send_packet(0, 0);
            send_packet(0, 5);
          end
          begin
            send_packet(1, 3);
            send_packet(1, 1);
          end
          begin
            send_packet(2, 6);
            send_packet(2, 0);
            send_packet(2, 2);
          end
          begin
            send_packet(3, 1);
            send_packet(3, 4);
          end
        join
        senders_done = 1'b1;
      end
      begin
        // random low stretches with short ready gaps between them
        while (!senders_done && guard < TIMEOUT) begin
          stretch = ($random(seed) & 7) + 1;
          out_ready <= 1'b0;
          repeat (stretch) @(posedge clk);
          guard += stretch;
          stretch = ($random(seed) & 3) + 1;
          out_ready <= 1'b1;
          repeat (stretch) @(posedge clk);
          guard += stretch;
        end
        if (!senders_done) begin
          report_error("timed out toggling ready while packets were still being sent");
        end
      end
    join
    out_ready <= 1'b1;
    wait_drain();
    order_q.delete();
  endtask

  task automatic full_level();
    int waited;
    apply_reset();
    out_ready <= 1'b0;
    // head goes to the output register, the body flits fill the buffer
    send_packet(1, noc_pkg::FIFO_DEPTH);
    @(posedge clk);
    check_value("in_full_o[1]", in_full[1], 1'b1);
    check_value("out_valid_o", out_valid, 1'b1);
    out_ready <= 1'b1;
    waited = 0;
    while (in_full[1] && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (in_full[1]) begin
      report_error("in_full_o of input 1 stayed high after ready returned");
    end
    wait_drain();
    order_q.delete();
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = '0;
    out_ready = 1'b1;
    for (int k = 0; k < noc_pkg::N_INPUTS; k++) begin
      in_flit[k] = '0;
    end
    reset_and_single_packet();
    round_robin_order();
    wormhole_lock();
    backpressure_stream();
    full_level();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/noc_pkg.sv
hw/flit_fifo.sv
hw/rr_arbiter.sv
hw/out_stage.sv
hw/noc_out_port.sv
dv/tb_noc_out_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the output port testbench with Verilator, runs it and judges the log
set -u

cd "$(dirname "$0")" || exit 1

top=tb_noc_out_port
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$top" -f sources.f -o "sim_$top"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./obj_dir/sim_$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$log"; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"
exit 0
